//--- rtl/CkePkg.sv
// clock-enable package: shared register types, register map and helper function
`default_nettype none

package CkePkg;

	// ------------------------------
	// basic widths
	// ------------------------------
	// register port address
	typedef logic [1:0] tRegAddr;
	// data word, also divider and tick count width
	typedef logic [15:0] tRegData;

	// ------------------------------
	// register map
	// ------------------------------
	// divider, pulse every div+1 cycles
	localparam tRegAddr cAddrDiv = 2'd0;
	// control, bit 0 enables the tick
	localparam tRegAddr cAddrCtrl = 2'd1;
	// tick count, read only
	localparam tRegAddr cAddrCount = 2'd2;
	// write strobe clears the count
	localparam tRegAddr cAddrClear = 2'd3;

	// programmable generator setup
	typedef struct packed {
		logic enable;
		tRegData div;
	} tCkeCfg;

	// bits needed to hold a count up to value, at least one
	function automatic int fBitWidth(input int value);
		int width;
		int rest;
		width = 1;
		rest = value >> 1;
		while (rest != 0)
		begin
			width++;
			rest = rest >> 1;
		end
		return width;
	endfunction

endpackage

`default_nettype wire

//--- rtl/CkeRegs.sv
// clock-enable register block: divider and control registers, count clear, read mux
`default_nettype none
`timescale 1ns/1ps

module CkeRegs
	import CkePkg::*;
(
	input  wire logic    iCLK,
	input  wire logic    iRST,
	// write strobe port
	input  wire logic    iWrEn,
	input  wire tRegAddr iWrAddr,
	input  wire tRegData iWrData,
	// combinational read port
	input  wire tRegAddr iRdAddr,
	output tRegData      oRdData,
	// live tick count for readback
	input  wire tRegData iCount,
	// generator setup and count clear
	output tCkeCfg       oCfg,
	output logic         oClear
);

	// register state
	tRegData divReg;
	logic enableReg;

	// ------------------------------
	// write decode
	// ------------------------------
	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			divReg <= '0;
			enableReg <= 1'b0;
		end
		else if (iWrEn)
		begin
			// count and clear addresses hold no state here
			case (iWrAddr)
				cAddrDiv:  divReg <= iWrData;
				cAddrCtrl: enableReg <= iWrData[0];
				default:   ;
			endcase
		end
	end

	// setup seen by the generator one cycle after the write
	assign oCfg.enable = enableReg;
	assign oCfg.div = divReg;

	// clear strobe in the write cycle itself
	assign oClear = iWrEn && (iWrAddr == cAddrClear);

	// ------------------------------
	// read mux
	// ------------------------------
	always_comb
	begin
		oRdData = '0;
		case (iRdAddr)
			cAddrDiv:   oRdData = divReg;
			// upper control bits read zero
			cAddrCtrl:  oRdData[0] = enableReg;
			cAddrCount: oRdData = iCount;
			// clear address reads zero
			default:    oRdData = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/CkeGenerator.sv
// clock-enable generator: fixed-rate or register-programmed single-cycle enable pulses
`default_nettype none
`timescale 1ns/1ps

module CkeGenerator
	import CkePkg::*;
#(
	// "yes" for register mode, "no" for fixed rate
	parameter string pDivReg = "no",
	// base period in cycles, fixed mode only
	parameter int pSysClk = 5,
	// base periods per pulse, fixed mode only
	parameter int pTimeCke = 1
)(
	input  wire logic   iCLK,
	input  wire logic   iRST,
	// divider and enable, register mode only
	input  wire tCkeCfg iCfg,
	output logic        oCke
);

	generate
		if (pDivReg == "yes")
		begin : gReg
			// ------------------------------
			// register-driven mode
			// ------------------------------
			tRegData divCount;
			logic ckeReg;
			logic divHit;

			// at or above div so a lowered divider still wraps
			assign divHit = (divCount >= iCfg.div);

			always_ff @(posedge iCLK)
			begin
				if (iRST)
				begin
					divCount <= '0;
					ckeReg <= 1'b0;
				end
				else if (!iCfg.enable)
				begin
					// idle, restart from zero on next enable
					divCount <= '0;
					ckeReg <= 1'b0;
				end
				else if (divHit)
				begin
					divCount <= '0;
					ckeReg <= 1'b1;
				end
				else
				begin
					divCount <= divCount + 1'b1;
					ckeReg <= 1'b0;
				end
			end

			// div of 0 keeps this high every cycle
			assign oCke = ckeReg;
		end
		else
		begin : gFixed
			// ------------------------------
			// fixed-rate mode
			// ------------------------------
			localparam int cBaseWidth = fBitWidth(pSysClk - 1);
			localparam int cPeriodWidth = fBitWidth(pTimeCke - 1);
			localparam logic [cBaseWidth-1:0] cBaseLast = cBaseWidth'(pSysClk - 1);
			localparam logic [cPeriodWidth-1:0] cPeriodLast = cPeriodWidth'(pTimeCke - 1);

			logic [cBaseWidth-1:0] baseCount;
			logic [cPeriodWidth-1:0] periodCount;
			logic baseWrap;
			logic periodWrap;
			logic ckeReg;

			// last cycle of a base period
			assign baseWrap = (baseCount == cBaseLast);
			// last base period of a beat
			assign periodWrap = (periodCount == cPeriodLast);

			// base counter, 0 .. pSysClk-1
			always_ff @(posedge iCLK)
			begin
				if (iRST || baseWrap)
					baseCount <= '0;
				else
					baseCount <= baseCount + 1'b1;
			end

			// counts base wraps, 0 .. pTimeCke-1
			always_ff @(posedge iCLK)
			begin
				if (iRST)
					periodCount <= '0;
				else if (baseWrap)
					periodCount <= periodWrap ? '0 : periodCount + 1'b1;
			end

			// one-cycle pulse after the final wrap
			always_ff @(posedge iCLK)
			begin
				if (iRST)
					ckeReg <= 1'b0;
				else
					ckeReg <= baseWrap && periodWrap;
			end

			// iCfg is not used here, rate is fixed at build time
			assign oCke = ckeReg;
		end
	endgenerate

endmodule

`default_nettype wire

//--- rtl/TickCounter.sv
// tick counter: counts enable pulses with clear priority and saturation
`default_nettype none
`timescale 1ns/1ps

module TickCounter
	import CkePkg::*;
(
	input  wire logic iCLK,
	input  wire logic iRST,
	// one per enable pulse
	input  wire logic iInc,
	// clear strobe from the register block
	input  wire logic iClear,
	output tRegData   oCount
);

	// ------------------------------
	// event counter
	// ------------------------------
	tRegData count;
	logic atMax;

	// full scale reached, hold there
	assign atMax = (count == '1);

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			count <= '0;
		end
		else if (iClear)
		begin
			// clear beats a same-cycle increment
			count <= '0;
		end
		else if (iInc && !atMax)
		begin
			count <= count + 1'b1;
		end
	end

	// readback through the register block
	assign oCount = count;

endmodule

`default_nettype wire

//--- rtl/CkeTop.sv
// clock-enable top: register block, tick and heartbeat generators, tick counter
`default_nettype none
`timescale 1ns/1ps

module CkeTop
	import CkePkg::*;
#(
	// heartbeat base period in cycles
	parameter int pSysClk = 5,
	// base periods per heartbeat
	parameter int pTimeCke = 3
)(
	input  wire logic    iCLK,
	input  wire logic    iRST,
	// register write strobe
	input  wire logic    iWrEn,
	input  wire tRegAddr iWrAddr,
	input  wire tRegData iWrData,
	// register read, combinational
	input  wire tRegAddr iRdAddr,
	output tRegData      oRdData,
	// enable pulses
	output logic         oTick,
	output logic         oBeat
);

	// ------------------------------
	// internal wiring
	// ------------------------------
	tCkeCfg cfg;
	logic clear;
	tRegData count;

	// registers and read mux
	CkeRegs CkeRegs_i (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.iWrEn   (iWrEn),
		.iWrAddr (iWrAddr),
		.iWrData (iWrData),
		.iRdAddr (iRdAddr),
		.oRdData (oRdData),
		.iCount  (count),
		.oCfg    (cfg),
		.oClear  (clear)
	);

	// programmable tick
	CkeGenerator #(
		.pDivReg  ("yes"),
		.pSysClk  (pSysClk),
		.pTimeCke (pTimeCke)
	) CkeTick_i (
		.iCLK (iCLK),
		.iRST (iRST),
		.iCfg (cfg),
		.oCke (oTick)
	);

	// fixed heartbeat, setup tied off
	CkeGenerator #(
		.pDivReg  ("no"),
		.pSysClk  (pSysClk),
		.pTimeCke (pTimeCke)
	) CkeBeat_i (
		.iCLK (iCLK),
		.iRST (iRST),
		.iCfg ('0),
		.oCke (oBeat)
	);

	// counts tick pulses for software
	TickCounter TickCounter_i (
		.iCLK   (iCLK),
		.iRST   (iRST),
		.iInc   (oTick),
		.iClear (clear),
		.oCount (count)
	);

endmodule

`default_nettype wire

//--- sim/CkeTop_asserts.sv
// clock-enable assertions: heartbeat width, count stability and tick shutdown
`default_nettype none
`timescale 1ns/1ps

module CkeTop_asserts
	import CkePkg::*;
(
	input wire logic    iCLK,
	input wire logic    iRST,
	input wire logic    tick,
	input wire logic    beat,
	// generator setup from the register block
	input wire tCkeCfg  cfg,
	input wire logic    clear,
	input wire tRegData count
);

	// ------------------------------
	// pulse properties
	// ------------------------------
	// heartbeat never wider than one cycle
	beatSingle: assert property (@(posedge iCLK) disable iff (iRST)
		beat |=> !beat)
		else $error("oBeat high on two consecutive cycles");

	// no increment and no clear, so count holds
	countHold: assert property (@(posedge iCLK) disable iff (iRST)
		(!tick && !clear) |=> $stable(count))
		else $error("tick count changed without increment or clear");

	// tick drops one cycle after enable is seen low
	tickOff: assert property (@(posedge iCLK) disable iff (iRST)
		!cfg.enable |=> !tick)
		else $error("oTick high after the enable was seen low");

endmodule

bind CkeTop CkeTop_asserts CkeTop_asserts_i (
	.iCLK  (iCLK),
	.iRST  (iRST),
	.tick  (oTick),
	.beat  (oBeat),
	.cfg   (cfg),
	.clear (clear),
	.count (count)
);

`default_nettype wire

//--- sim/CkeTb.sv
// clock-enable testbench with table-driven tick runs, count readback and heartbeat checks
`default_nettype none
`timescale 1ns/1ps

module CkeTb
	import CkePkg::*;
();

	// ------------------------------
	// constants
	// ------------------------------
	localparam int cClkPeriod = 10;
	localparam int cSysClk = 5;
	localparam int cTimeCke = 3;
	// heartbeat period in cycles
	localparam int cBeatPeriod = cSysClk * cTimeCke;
	localparam int cNumSteps = 6;
	localparam int cTimeoutMargin = 200;

	// one table row
	typedef struct packed {
		tRegData div;
		logic enable;
		tRegData window;
		logic clear;
	} tStep;

	logic iCLK;
	logic iRST;
	logic iWrEn;
	tRegAddr iWrAddr;
	tRegData iWrData;
	tRegAddr iRdAddr;
	tRegData oRdData;
	logic oTick;
	logic oBeat;

	// bookkeeping
	int cycleCount = 0;
	int resetCycle;
	int timeoutLimit;
	int errors;
	int checks;
	int expCount;
	int tickCycles[$];
	int beatCycles[$];
	tStep steps[cNumSteps];

	CkeTop #(
		.pSysClk  (cSysClk),
		.pTimeCke (cTimeCke)
	) CkeTop_i (
		.iCLK    (iCLK),
		.iRST    (iRST),
		.iWrEn   (iWrEn),
		.iWrAddr (iWrAddr),
		.iWrData (iWrData),
		.iRdAddr (iRdAddr),
		.oRdData (oRdData),
		.oTick   (oTick),
		.oBeat   (oBeat)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #(cClkPeriod / 2) iCLK = ~iCLK;
	end

	// cycle count and watchdog
	always @(posedge iCLK)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutLimit)
		begin
			$display("run did not finish within %0d cycles", timeoutLimit);
			$display("Test failed");
			$finish;
		end
	end

	// pulse monitors sampled mid-cycle
	always @(negedge iCLK)
	begin
		if (oTick)
			tickCycles.push_back(cycleCount);
		if (oBeat)
			beatCycles.push_back(cycleCount);
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic tStep makeStep(input int div, input bit enable, input int window,
		input bit clear);
		tStep step;
		step.div = tRegData'(div);
		step.enable = enable;
		step.window = tRegData'(window);
		step.clear = clear;
		return step;
	endfunction

	task automatic checkEqual(input string name, input int expected, input int actual);
		checks++;
		if (actual != expected)
		begin
			errors++;
			$display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
		end
	endtask

	// one-cycle write strobe that returns 1 ns after the write edge
	task automatic writeReg(input tRegAddr addr, input tRegData data);
		iWrEn = 1'b1;
		iWrAddr = addr;
		iWrData = data;
		@(posedge iCLK);
		#1;
		iWrEn = 1'b0;
	endtask

	task automatic readReg(input tRegAddr addr, output tRegData data);
		iRdAddr = addr;
		@(negedge iCLK);
		data = oRdData;
		@(posedge iCLK);
		#1;
	endtask

	// pulse k lands k*(div+1) cycles after the enable write edge
	task automatic checkTicks(input tStep step, input int enableCycle);
		int period;
		int expTicks;
		int i;
		period = step.div + 1;
		expTicks = step.enable ? step.window / period : 0;
		checkEqual("oTick pulse count", expTicks, tickCycles.size());
		for (i = 0; i < tickCycles.size(); i++)
			checkEqual("oTick pulse cycle", enableCycle + (i + 1) * period, tickCycles[i]);
	endtask

	task automatic checkBeats();
		int i;
		checks++;
		if (beatCycles.size() == 0)
		begin
			errors++;
			$display("no heartbeat pulse was seen on oBeat");
		end
		for (i = 0; i < beatCycles.size(); i++)
			checkEqual("oBeat pulse cycle", resetCycle + (i + 1) * cBeatPeriod, beatCycles[i]);
	endtask

	// ------------------------------
	// one table row
	// ------------------------------
	task automatic runStep(input tStep step);
		tRegData value;
		int enableCycle;
		int period;
		if (step.clear)
		begin
			writeReg(cAddrClear, 16'h0000);
			readReg(cAddrCount, value);
			checkEqual("count after clear", 0, value);
			expCount = 0;
		end
		writeReg(cAddrDiv, step.div);
		readReg(cAddrDiv, value);
		checkEqual("divider readback", step.div, value);
		tickCycles.delete();
		// upper control bits written high but read back as zero
		writeReg(cAddrCtrl, {15'h7FFF, step.enable});
		enableCycle = cycleCount;
		// combinational read port sampled well inside the cycle
		iRdAddr = cAddrCtrl;
		#2;
		checkEqual("control readback", step.enable, oRdData);
		// disable edge lands window cycles after the enable edge
		repeat (step.window - 1) @(posedge iCLK);
		#1;
		writeReg(cAddrCtrl, 16'h0000);
		// last pulse still reaches the counter
		repeat (2) @(posedge iCLK);
		#1;
		period = step.div + 1;
		if (step.enable)
			expCount = expCount + step.window / period;
		if (expCount > 16'hFFFF)
			expCount = 16'hFFFF;
		readReg(cAddrCount, value);
		checkEqual("tick count", expCount, value);
		// clear address reads zero even with a live count
		readReg(cAddrClear, value);
		checkEqual("clear address readback", 0, value);
		checkTicks(step, enableCycle);
	endtask

	// ------------------------------
	// main sequence
	// ------------------------------
	initial
	begin
		tRegData value;
		int i;
		iRST = 1'b1;
		iWrEn = 1'b0;
		iWrAddr = '0;
		iWrData = '0;
		iRdAddr = '0;
		errors = 0;
		checks = 0;
		expCount = 0;
		// div, enable, window and clear-first flag
		steps[0] = makeStep(0, 1'b1, 20, 1'b1);
		steps[1] = makeStep(1, 1'b1, 30, 1'b0);
		steps[2] = makeStep(4, 1'b1, 47, 1'b0);
		steps[3] = makeStep(9, 1'b1, 100, 1'b1);
		// enable off so the count must hold
		steps[4] = makeStep(9, 1'b0, 40, 1'b0);
		steps[5] = makeStep(3, 1'b1, 25, 1'b1);
		timeoutLimit = cTimeoutMargin;
		for (i = 0; i < cNumSteps; i++)
			timeoutLimit = timeoutLimit + steps[i].window;

		repeat (4) @(posedge iCLK);
		#1;
		iRST = 1'b0;
		resetCycle = cycleCount;

		checkEqual("oTick after reset", 0, oTick);
		checkEqual("oBeat after reset", 0, oBeat);
		for (i = 0; i < 4; i++)
		begin
			readReg(tRegAddr'(i), value);
			checkEqual($sformatf("register %0d after reset", i), 0, value);
		end

		for (i = 0; i < cNumSteps; i++)
			runStep(steps[i]);
		checkBeats();

		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
rtl/CkePkg.sv
rtl/CkeRegs.sv
rtl/CkeGenerator.sv
rtl/TickCounter.sv
rtl/CkeTop.sv
sim/CkeTop_asserts.sv
sim/CkeTb.sv

//--- Bender.yml
package:
  name: cke_top

sources:
  # package first, then leaf blocks, then the top level
  - rtl/CkePkg.sv
  - rtl/CkeRegs.sv
  - rtl/CkeGenerator.sv
  - rtl/TickCounter.sv
  - rtl/CkeTop.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/CkeTop_asserts.sv
      - sim/CkeTb.sv
